// ==== audio_pkg.sv ====
// Datapath types for the audio compressor pipeline, shared by every stage.
// Stages pull these in with a wildcard import in their module header.
package audio_pkg;

    typedef logic signed [15:0] sample_t;            // Signed PCM sample
    typedef logic [14:0]        mag_t;               // Saturated magnitude, 0 to 32767

    localparam sample_t SAMPLE_MIN = 16'sh8000;       // Full-scale negative input
    localparam mag_t    MAG_MAX    = 15'h7fff;       // Where -32768 saturates to
    localparam int      LEVEL_LSB  = 11;             // Threshold step is 2048

    // CTRL register layout, bypass sits in bit 4 above the threshold
    typedef struct packed {
        logic       bypass;                          // Pass samples untouched
        logic [3:0] threshold;                       // Level in steps of 2048
    } comp_cfg_t;

    // Window beat depends on the window depth, so it lives in a parameterized scope
    class win_types #(parameter int DEPTH = 4);
        typedef struct packed {
            logic                 valid;             // Sample entered this cycle
            sample_t              sample;            // Oldest sample in the window
            mag_t [DEPTH-1:0]     mags;              // Magnitudes, oldest at index 0
        } win_beat_t;
    endclass

    typedef struct packed {
        logic    valid;
        sample_t sample;                             // Oldest sample
        mag_t    mag;                                // Its magnitude
        mag_t    peak;                               // Largest magnitude in window
    } peak_beat_t;

    typedef struct packed {
        logic        valid;
        sample_t     sample;                         // Oldest sample, still unmodified
        logic [15:0] modifier;                       // Amount to pull toward zero
        logic        active;                         // Valid beat with nonzero modifier
    } gain_beat_t;

endpackage

// ==== wb_regs_pkg.sv ====
// Wishbone classic bus structs and the register map of the compressor slave.
package wb_regs_pkg;

    typedef logic [1:0] wb_adr_t;                    // Word address of a register

    typedef struct packed {
        logic        cyc;                            // Bus cycle in progress
        logic        stb;                            // Transfer strobe
        logic        we;                             // Write when high
        wb_adr_t     adr;
        logic [15:0] dat;                            // Write data
    } wb_req_t;

    typedef struct packed {
        logic        ack;                            // One-cycle acknowledge
        logic [15:0] dat;                            // Read data, valid with ack
    } wb_rsp_t;

    localparam wb_adr_t REG_CTRL  = 2'd0;            // Threshold and bypass
    localparam wb_adr_t REG_PEAK  = 2'd1;            // Peak hold, write clears
    localparam wb_adr_t REG_COUNT = 2'd2;            // Compressed sample count, write clears

endpackage

// ==== sample_window.sv ====
// Pipeline stage 1, keeps the last WINDOW_DEPTH samples and their magnitudes.
// Shifts on each valid input and presents the oldest sample with all magnitudes.
`timescale 1ns/10ps

module sample_window
    import audio_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4                   // History length, power of two
) (
    input  logic    clk,
    input  logic    reset,
    input  sample_t sample_in,
    input  logic    sample_valid,
    output win_types#(WINDOW_DEPTH)::win_beat_t win
);

    sample_t [WINDOW_DEPTH-1:0] hist_sample;         // Index 0 is the oldest
    mag_t    [WINDOW_DEPTH-1:0] hist_mag;            // Magnitude stored beside each sample
    mag_t                       in_mag;              // Magnitude of the entering sample
    sample_t                    in_neg;              // Two's complement of the input
    logic                       win_valid;

    assign in_neg = -sample_in;

    // Absolute value computed once at the door
    always_comb begin
        if (sample_in == SAMPLE_MIN) begin
            in_mag = MAG_MAX;                        // -32768 has no positive twin
        end else if (sample_in[15]) begin
            in_mag = in_neg[14:0];
        end else begin
            in_mag = sample_in[14:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_valid   <= 1'b0;
            hist_sample <= '0;                       // Start from silence
            hist_mag    <= '0;
        end else begin
            win_valid <= sample_valid;
            if (sample_valid) begin
                hist_sample <= {sample_in, hist_sample[WINDOW_DEPTH-1:1]};  // Newest on top
                hist_mag    <= {in_mag, hist_mag[WINDOW_DEPTH-1:1]};
            end
        end
    end

    assign win.valid  = win_valid;
    assign win.sample = hist_sample[0];
    assign win.mags   = hist_mag;

endmodule

// ==== peak_detect.sv ====
// Pipeline stage 2, finds the largest magnitude in the window with a compare tree.
// Registers the peak with the oldest sample and its magnitude.
`timescale 1ns/10ps

module peak_detect
    import audio_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  win_types#(WINDOW_DEPTH)::win_beat_t win,
    output peak_beat_t peak
);

    mag_t window_max;                                // Root of the tree

    // Pairwise max, each pass halves the number of candidates
    function automatic mag_t tree_max(input mag_t [WINDOW_DEPTH-1:0] mags);
        mag_t [WINDOW_DEPTH-1:0] lvl;
        lvl = mags;
        for (int w = WINDOW_DEPTH / 2; w >= 1; w = w / 2) begin
            for (int i = 0; i < w; i++) begin
                lvl[i] = (lvl[2*i] >= lvl[2*i+1]) ? lvl[2*i] : lvl[2*i+1];
            end
        end
        return lvl[0];
    endfunction

    assign window_max = tree_max(win.mags);

    always_ff @(posedge clk) begin
        if (reset) begin
            peak.valid <= 1'b0;
        end else begin
            peak.valid <= win.valid;                 // Bubbles ride along
        end
        peak.sample <= win.sample;
        peak.mag    <= win.mags[0];                  // Oldest magnitude
        peak.peak   <= window_max;
    end

endmodule

// ==== comp_gain.sv ====
// Pipeline stage 3, turns the window peak into a reduction amount.
// Excess over the threshold times the sample magnitude, scaled down by the peak octave.
`timescale 1ns/10ps

module comp_gain
    import audio_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  peak_beat_t peak,
    input  comp_cfg_t  cfg,
    output gain_beat_t gain
);

    logic [15:0] level;                              // Threshold in sample units
    logic [15:0] excess;                             // Peak minus level, bit 15 is borrow
    logic [3:0]  excess_m;                           // Top four bits of the excess
    logic        enable;
    logic [18:0] product;                            // 15 x 4 bit product
    logic [15:0] modifier;

    assign level    = 16'(cfg.threshold) << LEVEL_LSB;
    assign excess   = {1'b0, peak.peak} - level;
    assign excess_m = excess[LEVEL_LSB+3:LEVEL_LSB];
    assign enable   = !cfg.bypass && !excess[15];    // Peak at or above level
    assign product  = peak.mag * excess_m;

    // Octave shift picked by the leading peak bit
    always_comb begin
        modifier = '0;
        if (enable) begin
            if (peak.peak[14]) begin
                modifier = 16'(product >> 15);
            end else if (peak.peak[13]) begin
                modifier = 16'(product >> 14);
            end else if (peak.peak[12]) begin
                modifier = 16'(product >> 13);
            end else if (peak.peak[11]) begin
                modifier = 16'(product >> 12);
            end
            // Quiet peaks below 2048 leave the sample alone
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gain.valid  <= 1'b0;
            gain.active <= 1'b0;
        end else begin
            gain.valid  <= peak.valid;
            gain.active <= peak.valid && (modifier != '0);  // One pulse per compressed beat
        end
        gain.sample   <= peak.sample;
        gain.modifier <= modifier;
    end

endmodule

// ==== sign_restore.sv ====
// Pipeline stage 4, pulls the oldest sample toward zero by the modifier.
// Negative samples get the modifier added, others get it subtracted.
`timescale 1ns/10ps

module sign_restore
    import audio_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  gain_beat_t gain,
    output sample_t    sample_out,
    output logic       out_valid
);

    sample_t mod_s;                                  // Modifier as a signed value
    sample_t restored;

    assign mod_s = sample_t'(gain.modifier);

    always_comb begin
        if (gain.sample[15]) begin
            restored = gain.sample + mod_s;          // Toward zero from below
        end else begin
            restored = gain.sample - mod_s;          // Toward zero from above
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= gain.valid;
        end
    end

    // Output holds its last value through bubbles
    always_ff @(posedge clk) begin
        if (gain.valid) begin
            sample_out <= restored;
        end
    end

endmodule

// ==== comp_csr.sv ====
// Wishbone classic slave with control, peak-hold and compressed-count registers.
// Ack comes one cycle after the request and lasts a single cycle.
`timescale 1ns/10ps

module comp_csr
    import audio_pkg::*;
    import wb_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output comp_cfg_t  cfg,
    input  peak_beat_t peak,
    input  logic       active
);

    comp_cfg_t   ctrl_q;
    mag_t        peak_hold;                          // Largest peak since last clear
    logic [15:0] comp_count;                         // Saturating beat counter
    logic        ack_q;
    logic [15:0] rd_dat_q;
    logic [15:0] rd_mux;
    logic        wb_hit;                             // New request this cycle
    logic        wr_en;

    assign wb_hit = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_en  = wb_hit && wb_req.we;

    always_comb begin
        case (wb_req.adr)
            REG_CTRL:  rd_mux = 16'(ctrl_q);
            REG_PEAK:  rd_mux = {1'b0, peak_hold};
            REG_COUNT: rd_mux = comp_count;
            default:   rd_mux = '0;                  // Unmapped word reads zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q      <= 1'b0;
            ctrl_q     <= '{bypass: 1'b0, threshold: 4'd15};
            peak_hold  <= '0;
            comp_count <= '0;
        end else begin
            ack_q <= wb_hit;
            if (wr_en && wb_req.adr == REG_CTRL) begin
                ctrl_q <= comp_cfg_t'(wb_req.dat[$bits(comp_cfg_t)-1:0]);
            end
            if (wr_en && wb_req.adr == REG_PEAK) begin
                peak_hold <= '0;                     // Any write value clears
            end else if (peak.valid && peak.peak > peak_hold) begin
                peak_hold <= peak.peak;
            end
            if (wr_en && wb_req.adr == REG_COUNT) begin
                comp_count <= '0;
            end else if (active && comp_count != '1) begin
                comp_count <= comp_count + 16'd1;    // Stops at 65535
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge clk) begin
        if (wb_hit) begin
            rd_dat_q <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;
    assign cfg        = ctrl_q;

endmodule

// ==== amp_compressor.sv ====
// Top of the streaming amplitude compressor, four pipeline stages plus the CSR slave.
// Output appears four cycles after the input sample that triggers it.
`timescale 1ns/10ps

module amp_compressor
    import audio_pkg::*;
    import wb_regs_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4                   // Power of two, 2 to 8
) (
    input  logic    clk,
    input  logic    reset,
    input  sample_t sample_in,
    input  logic    sample_valid,
    output sample_t sample_out,
    output logic    out_valid,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    win_types#(WINDOW_DEPTH)::win_beat_t win_beat;   // Stage 1 to 2
    peak_beat_t peak_beat;                           // Stage 2 to 3 and CSR
    gain_beat_t gain_beat;                           // Stage 3 to 4
    comp_cfg_t  cfg;                                 // CSR to stage 3

    sample_window #(.WINDOW_DEPTH(WINDOW_DEPTH)) u_window (
        .clk          (clk),
        .reset        (reset),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .win          (win_beat)
    );

    peak_detect #(.WINDOW_DEPTH(WINDOW_DEPTH)) u_peak (
        .clk   (clk),
        .reset (reset),
        .win   (win_beat),
        .peak  (peak_beat)
    );

    comp_gain u_gain (
        .clk   (clk),
        .reset (reset),
        .peak  (peak_beat),
        .cfg   (cfg),
        .gain  (gain_beat)
    );

    sign_restore u_restore (
        .clk        (clk),
        .reset      (reset),
        .gain       (gain_beat),
        .sample_out (sample_out),
        .out_valid  (out_valid)
    );

    comp_csr u_csr (
        .clk    (clk),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .cfg    (cfg),
        .peak   (peak_beat),
        .active (gain_beat.active)                   // Already qualified by valid
    );

endmodule

// ==== amp_compressor_props.sv ====
// Concurrent checks bound into the compressor top for bus and pipeline timing rules.
`timescale 1ns/10ps

module amp_compressor_props
    import audio_pkg::*;
    import wb_regs_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       sample_valid,
    input logic       out_valid,
    input sample_t    sample_out,
    input wb_rsp_t    wb_rsp,
    input gain_beat_t gain_beat                      // Beat feeding the output register
);

    int unsigned fail_count = 0;
    logic [15:0] out_mag;                            // Unsaturated, -32768 gives 32768
    logic [15:0] oldest_mag;

    assign out_mag    = sample_out[15] ? (16'd0 - sample_out) : sample_out;
    assign oldest_mag = gain_beat.sample[15] ? (16'd0 - gain_beat.sample) : gain_beat.sample;

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> !$past(wb_rsp.ack))
        else begin
            fail_count++;
            $error("ack stayed high for more than one cycle");
        end

    out_follows_in: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(sample_valid, 4))
        else begin
            fail_count++;
            $error("out_valid does not follow sample_valid by 4 cycles");
        end

    no_gain: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> out_mag <= $past(oldest_mag))
        else begin
            fail_count++;
            $error("output magnitude grew past the oldest sample");
        end

endmodule

// ==== comp_checker.sv ====
// Reference model of the compressor, watches the DUT ports and compares outputs and reads.
// Keeps its own window, peak-hold and count built from the sample stream and the bus.
`timescale 1ns/10ps

module comp_checker
    import audio_pkg::*;
    import wb_regs_pkg::*;
#(
    parameter int WINDOW_DEPTH = 4
) (
    input  logic    clk,
    input  logic    reset,
    input  sample_t sample_in,
    input  logic    sample_valid,
    input  sample_t sample_out,
    input  logic    out_valid,
    input  wb_req_t wb_req,
    input  wb_rsp_t wb_rsp,
    input  int      count_expect,                    // Fixed COUNT value, negative when free
    output int      pending,                         // Outputs the DUT still owes
    output int      error_count
);

    int         win_m [WINDOW_DEPTH];                // Model history, index 0 oldest
    int         exp_q [$];                           // Predicted outputs in order
    logic [3:0] thr_m;
    logic       byp_m;
    int         peak_m;                              // Expected peak-hold
    int         count_m;                             // Expected compressed count

    function automatic int magnitude(input int s);
        if (s == -32768) return 32767;               // Saturates
        return (s < 0) ? -s : s;
    endfunction

    function automatic int reduction(input int mag, input int pk, input logic [3:0] thr,
                                     input logic byp);
        int level;
        int shift;
        level = int'(thr) * 2048;
        if (byp || pk < level || pk < 2048) return 0;
        shift = (pk >= 16384) ? 15 : (pk >= 8192) ? 14 : (pk >= 4096) ? 13 : 12;
        return (mag * (((pk - level) >> 11) & 15)) >> shift;
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        if (expected != actual) begin
            error_count++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    initial error_count = 0;

    always @(posedge clk) begin
        int pk;
        int oldest;
        int red;
        if (reset) begin
            foreach (win_m[i]) win_m[i] = 0;
            exp_q.delete();
            thr_m   = 4'd15;
            byp_m   = 1'b0;
            peak_m  = 0;
            count_m = 0;
        end else begin
            if (out_valid && exp_q.size() == 0) begin
                error_count++;
                $display("out_valid high at %0t with no accepted sample behind it", $time);
            end else if (out_valid) begin
                compare("sample_out", exp_q.pop_front(), int'(sample_out));
            end
            if (sample_valid) begin
                for (int i = 0; i < WINDOW_DEPTH - 1; i++) win_m[i] = win_m[i + 1];
                win_m[WINDOW_DEPTH - 1] = int'(sample_in);
                pk = 0;
                foreach (win_m[i]) if (magnitude(win_m[i]) > pk) pk = magnitude(win_m[i]);
                oldest = win_m[0];
                red    = reduction(magnitude(oldest), pk, thr_m, byp_m);
                exp_q.push_back((oldest < 0) ? oldest + red : oldest - red);  // Toward zero
                if (pk > peak_m) peak_m = pk;
                if (red != 0 && count_m < 65535) count_m++;
            end
            if (wb_rsp.ack && wb_req.we) begin
                case (wb_req.adr)
                    REG_CTRL: begin
                        thr_m = wb_req.dat[3:0];
                        byp_m = wb_req.dat[4];
                    end
                    REG_PEAK:  peak_m  = 0;
                    REG_COUNT: count_m = 0;
                    default: ;
                endcase
            end else if (wb_rsp.ack) begin
                case (wb_req.adr)
                    REG_CTRL:  compare("CTRL", int'({byp_m, thr_m}), int'(wb_rsp.dat));
                    REG_PEAK:  compare("PEAK", peak_m, int'(wb_rsp.dat));
                    REG_COUNT: begin
                        compare("COUNT", count_m, int'(wb_rsp.dat));
                        if (count_expect >= 0) compare("COUNT", count_expect, int'(wb_rsp.dat));
                    end
                    default: ;
                endcase
            end
        end
        pending = exp_q.size();
    end

endmodule

// ==== tb_amp_compressor.sv ====
// Audio compressor testbench that streams a table of patterns and reads the registers back.
// Comparing is done in comp_checker and timing rules sit in the bound property module.
`timescale 1ns/10ps

module tb_amp_compressor
    import audio_pkg::*;
    import wb_regs_pkg::*;
();

    localparam int WINDOW_DEPTH  = 4;
    localparam int NUM_ENTRIES   = 12;
    localparam int ACK_TIMEOUT   = 20;                // Cycles allowed for one Wishbone ack
    localparam int DRAIN_TIMEOUT = 50;                // Cycles allowed to empty the pipeline

    typedef enum logic [1:0] {PAT_CONST, PAT_ALT, PAT_FULLNEG, PAT_RANDOM} pattern_t;

    typedef struct packed {
        logic [3:0]         threshold;
        logic               bypass;
        logic [7:0]         n_samples;
        pattern_t           kind;
        logic signed [15:0] amp;                     // Level for the fixed patterns
        logic signed [7:0]  count_inc;               // Expected COUNT or negative when model decides
    } stim_entry_t;

    logic        clk = 1'b0;
    logic        reset;
    sample_t     sample_in;
    logic        sample_valid;
    sample_t     sample_out;
    logic        out_valid;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          count_expect;                       // Passed to the checker for COUNT reads
    int          pending;
    int          checker_errors;
    int          tb_errors;
    logic [15:0] lfsr;
    stim_entry_t stim [NUM_ENTRIES];

    always #5 clk = ~clk;                            // 10 ns period

    amp_compressor #(.WINDOW_DEPTH(WINDOW_DEPTH)) DUT (
        .clk(clk), .reset(reset), .sample_in(sample_in), .sample_valid(sample_valid),
        .sample_out(sample_out), .out_valid(out_valid), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    comp_checker #(.WINDOW_DEPTH(WINDOW_DEPTH)) u_checker (
        .clk(clk), .reset(reset), .sample_in(sample_in), .sample_valid(sample_valid),
        .sample_out(sample_out), .out_valid(out_valid), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .count_expect(count_expect), .pending(pending), .error_count(checker_errors)
    );

    bind amp_compressor amp_compressor_props u_props (
        .clk(clk), .reset(reset), .sample_valid(sample_valid), .out_valid(out_valid),
        .sample_out(sample_out), .wb_rsp(wb_rsp), .gain_beat(gain_beat)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr[15]};           // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic bus_transfer(input logic write, input wb_adr_t addr,
                                input logic [15:0] wdata);
        int waited;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: write, adr: addr, dat: wdata};
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            tb_errors++;
            $display("Wishbone ack never came for address %0d at %0t", addr, $time);
        end
        wb_req.cyc = 1'b0;                           // Address and data stay put
        wb_req.stb = 1'b0;
    endtask

    task automatic send_sample(input sample_t s);
        @(negedge clk);
        sample_in    = s;
        sample_valid = 1'b1;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        sample_valid = 1'b0;
    endtask

    task automatic drain_pipeline();
        int waited;
        idle_cycle();
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("Pipeline still owed %0d outputs after the drain wait at %0t", pending, $time);
        end
    endtask

    task automatic run_entry(input stim_entry_t e);
        logic [15:0] bits;
        sample_t     s;
        bus_transfer(1'b1, REG_CTRL, {11'd0, e.bypass, e.threshold});
        bus_transfer(1'b0, REG_CTRL, 16'd0);
        bus_transfer(1'b1, REG_PEAK, 16'hffff);      // Any data clears
        bus_transfer(1'b1, REG_COUNT, 16'h1234);
        count_expect = 0;
        bus_transfer(1'b0, REG_PEAK, 16'd0);
        bus_transfer(1'b0, REG_COUNT, 16'd0);
        for (int k = 0; k < int'(e.n_samples); k++) begin
            case (e.kind)
                PAT_CONST:   s = e.amp;
                PAT_ALT:     s = k[0] ? -e.amp : e.amp;
                PAT_FULLNEG: s = 16'sh8000;
                default: begin
                    take_bits(1, bits);
                    if (bits[0]) idle_cycle();       // Random gap in the stream
                    take_bits(16, bits);
                    s = sample_t'(bits);
                end
            endcase
            send_sample(s);
        end
        for (int k = 0; k < WINDOW_DEPTH - 1; k++) begin
            send_sample('0);                         // Tail becomes oldest
        end
        drain_pipeline();
        count_expect = int'(e.count_inc);
        bus_transfer(1'b0, REG_PEAK, 16'd0);
        bus_transfer(1'b0, REG_COUNT, 16'd0);
    endtask

    initial begin
        reset        = 1'b1;
        sample_in    = '0;
        sample_valid = 1'b0;
        wb_req       = '0;
        count_expect = 0;
        tb_errors    = 0;
        lfsr         = 16'd39014;
        stim[0]  = '{4'd15, 1'b0, 8'd12, PAT_CONST,   16'sd1000,   8'sd0};   // Quiet stream passes
        stim[1]  = '{4'd0,  1'b1, 8'd12, PAT_ALT,     16'sd30000,  8'sd0};   // Loud but bypassed
        stim[2]  = '{4'd8,  1'b1, 8'd8,  PAT_FULLNEG, 16'sd0,      8'sd0};
        stim[3]  = '{4'd8,  1'b0, 8'd10, PAT_FULLNEG, 16'sd0,      8'sd10};  // Modifier 6
        stim[4]  = '{4'd15, 1'b0, 8'd8,  PAT_CONST,   16'sd32767,  8'sd0};   // Excess under 2048
        stim[5]  = '{4'd4,  1'b0, 8'd10, PAT_ALT,     16'sd20000,  8'sd10};  // Shift 15
        stim[6]  = '{4'd0,  1'b0, 8'd10, PAT_CONST,   16'sd6000,   8'sd10};  // Shift 13
        stim[7]  = '{4'd0,  1'b0, 8'd10, PAT_CONST,  -16'sd12000,  8'sd10};  // Shift 14
        stim[8]  = '{4'd0,  1'b0, 8'd10, PAT_CONST,   16'sd4000,   8'sd0};   // Shift 12 rounds to 0
        stim[9]  = '{4'd0,  1'b0, 8'd48, PAT_RANDOM,  16'sd0,     -8'sd1};
        stim[10] = '{4'd4,  1'b0, 8'd48, PAT_RANDOM,  16'sd0,     -8'sd1};
        stim[11] = '{4'd8,  1'b0, 8'd48, PAT_RANDOM,  16'sd0,     -8'sd1};
        repeat (5) @(negedge clk);
        reset = 1'b0;
        bus_transfer(1'b0, REG_CTRL, 16'd0);         // Reset value of CTRL
        bus_transfer(1'b0, REG_PEAK, 16'd0);
        bus_transfer(1'b0, REG_COUNT, 16'd0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(stim[i]);
        end
        $display("error counts: checker %0d, testbench %0d, assertions %0d",
                 checker_errors, tb_errors, DUT.u_props.fail_count);
        if (checker_errors == 0 && tb_errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== amp_compressor.f ====
audio_pkg.sv
wb_regs_pkg.sv
sample_window.sv
peak_detect.sv
comp_gain.sv
sign_restore.sv
comp_csr.sv
amp_compressor.sv
amp_compressor_props.sv
comp_checker.sv
tb_amp_compressor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_amp_compressor
FILELIST  ?= amp_compressor.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
